// ==== logic/mpmc_pkg.sv ====
`default_nettype none

package mpmc_pkg;

	// ====================
	// Bus and memory widths
	// ====================

	// Byte address on both the Wishbone side and the application interface
	typedef logic [31:0] addr_t;

	// One Wishbone data word and its byte selects
	typedef logic [31:0] word_t;
	typedef logic [3:0] sel_t;

	// One memory strip as the controller core moves it
	typedef logic [127:0] strip_t;

	// Strip byte mask, where a set bit keeps the memory byte unchanged
	typedef logic [15:0] mask_t;

	// Strip counter for one line burst
	typedef logic [1:0] strip_cnt_t;

	// Line tag taken from address bits 31 to 5
	typedef logic [26:0] line_tag_t;

	// ====================
	// Line geometry
	// ====================

	// A line is two strips of sixteen bytes, aligned to 32 bytes
	localparam int line_strips = 2;
	localparam int strip_bytes = 16;

	// Wishbone words per strip, one write lane each
	localparam int strip_words = strip_bytes / 4;

	// ====================
	// Controller sequencing
	// ====================

	typedef enum logic [2:0] {
		idle,
		preset_rd,
		read_req,
		read_data,
		preset_wr,
		write_req,
		ack
	} mpmc_state_t;

endpackage

`default_nettype wire

// ==== logic/mpmc_addr_gen.sv ====
`default_nettype none

module mpmc_addr_gen (
	input  logic                  clk,
	input  logic                  rst,
	input  mpmc_pkg::mpmc_state_t state,
	input  logic                  app_rdy,
	input  logic                  req_last,
	input  mpmc_pkg::addr_t       wb_adr,
	output mpmc_pkg::addr_t       addr
);

	// The register drives app_addr directly, so the address is stable
	// from the cycle after a preset state until the core takes the request
	always_ff @(posedge clk) begin
		if (rst) begin
			// High bits all ones mark the address as not yet loaded
			addr <= {{28{1'b1}}, 4'h0};
		end else begin
			case (state)
				// A fetch starts at the 32 byte line base
				mpmc_pkg::preset_rd: addr <= {wb_adr[31:5], 5'h0};
				// A write goes to the single strip that holds the word
				mpmc_pkg::preset_wr: addr <= {wb_adr[31:4], 4'h0};
				mpmc_pkg::read_req: begin
					// Step to the next strip once a request is taken
					// The last request leaves addr on the final strip,
					// which still carries the line tag for the buffer
					if (app_rdy && !req_last)
						addr <= addr + mpmc_pkg::addr_t'(mpmc_pkg::strip_bytes);
				end
				default: begin
					// Address holds in all other states
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/mpmc_strip_counter.sv ====
`default_nettype none

module mpmc_strip_counter (
	input  logic                  clk,
	input  logic                  rst,
	input  mpmc_pkg::mpmc_state_t state,
	input  logic                  app_rdy,
	input  logic                  app_rd_data_valid,
	output mpmc_pkg::strip_cnt_t  req_cnt,
	output mpmc_pkg::strip_cnt_t  data_cnt,
	output logic                  req_last,
	output logic                  data_last
);

	// Requests are counted as the core accepts them
	// Returns are counted on each valid strip, which may arrive with gaps
	always_ff @(posedge clk) begin
		if (rst || state == mpmc_pkg::preset_rd) begin
			req_cnt <= '0;
			data_cnt <= '0;
		end else begin
			// app_en is high for the whole read_req state
			if (state == mpmc_pkg::read_req && app_rdy)
				req_cnt <= req_cnt + mpmc_pkg::strip_cnt_t'(1);
			if (app_rd_data_valid)
				data_cnt <= data_cnt + mpmc_pkg::strip_cnt_t'(1);
		end
	end

	// Flags for the final strip of the burst on each side
	assign req_last = (req_cnt == mpmc_pkg::strip_cnt_t'(mpmc_pkg::line_strips - 1));
	assign data_last = (data_cnt == mpmc_pkg::strip_cnt_t'(mpmc_pkg::line_strips - 1));

endmodule

`default_nettype wire

// ==== logic/mpmc_state_machine.sv ====
`default_nettype none

module mpmc_state_machine (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_read,
	input  logic                  start_write,
	input  logic                  app_rdy,
	input  logic                  req_last,
	input  logic                  data_last,
	input  logic                  app_rd_data_valid,
	output mpmc_pkg::mpmc_state_t state,
	output logic                  app_en,
	output logic                  app_cmd,
	output logic                  done_pulse
);

	mpmc_pkg::mpmc_state_t next_state;

	// ====================
	// Next state
	// ====================

	always_comb begin
		next_state = state;
		case (state)
			mpmc_pkg::idle: begin
				// A miss read wins if both were ever raised together
				if (start_read)
					next_state = mpmc_pkg::preset_rd;
				else if (start_write)
					next_state = mpmc_pkg::preset_wr;
			end
			mpmc_pkg::preset_rd: begin
				// One cycle for the address generator to load the line base
				next_state = mpmc_pkg::read_req;
			end
			mpmc_pkg::read_req: begin
				// Stay until the last strip request of the line is taken
				if (app_rdy && req_last)
					next_state = mpmc_pkg::read_data;
			end
			mpmc_pkg::read_data: begin
				// The final return closes the fetch
				// Earlier returns may land while requests are still going out
				if (app_rd_data_valid && data_last)
					next_state = mpmc_pkg::ack;
			end
			mpmc_pkg::preset_wr: begin
				next_state = mpmc_pkg::write_req;
			end
			mpmc_pkg::write_req: begin
				// Data and mask go with the request, so one accept ends it
				if (app_rdy)
					next_state = mpmc_pkg::ack;
			end
			mpmc_pkg::ack: begin
				next_state = mpmc_pkg::idle;
			end
			default: begin
				next_state = mpmc_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= mpmc_pkg::idle;
		else
			state <= next_state;
	end

	// ====================
	// Request outputs
	// ====================

	// app_en rises with the entry into a request state and falls the cycle
	// after the last request is taken, so it is high for all of read_req
	// and write_req and low everywhere else
	always_ff @(posedge clk) begin
		if (rst) begin
			app_en <= 1'b0;
			app_cmd <= 1'b1;
		end else begin
			case (state)
				mpmc_pkg::preset_rd: begin
					app_en <= 1'b1;
					app_cmd <= 1'b1;
				end
				mpmc_pkg::preset_wr: begin
					app_en <= 1'b1;
					app_cmd <= 1'b0;
				end
				mpmc_pkg::read_req: begin
					if (app_rdy && req_last)
						app_en <= 1'b0;
				end
				mpmc_pkg::write_req: begin
					if (app_rdy)
						app_en <= 1'b0;
				end
				default: begin
					// app_cmd keeps its last direction while idle
				end
			endcase
		end
	end

	// The Wishbone port turns this into wb_ack
	assign done_pulse = (state == mpmc_pkg::ack);

endmodule

`default_nettype wire

// ==== logic/mpmc_line_buffer.sv ====
`default_nettype none

module mpmc_line_buffer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  fill_en,
	input  mpmc_pkg::strip_cnt_t  fill_idx,
	input  mpmc_pkg::strip_t      fill_data,
	input  mpmc_pkg::line_tag_t   fill_tag,
	input  logic                  wr_en,
	input  mpmc_pkg::addr_t       wr_adr,
	input  mpmc_pkg::word_t       wr_data,
	input  mpmc_pkg::sel_t        wr_sel,
	input  mpmc_pkg::addr_t       rd_adr,
	output mpmc_pkg::word_t       rd_word,
	output mpmc_pkg::line_tag_t   line_tag,
	output logic                  line_valid
);

	mpmc_pkg::strip_t strips [mpmc_pkg::line_strips];
	mpmc_pkg::word_t old_word;
	mpmc_pkg::word_t merged_word;
	logic wr_hit;

	// Only a write into the buffered line touches the storage
	assign wr_hit = wr_en && line_valid && (line_tag == wr_adr[31:5]);

	// Bit 4 picks the strip and bits 3 to 2 the word within it
	assign old_word = strips[wr_adr[4]][{wr_adr[3:2], 5'h0} +: 32];

	// Bytes without a select keep their buffered value
	always_comb begin
		merged_word = old_word;
		for (int b = 0; b < 4; b++) begin
			if (wr_sel[b])
				merged_word[b*8 +: 8] = wr_data[b*8 +: 8];
		end
	end

	// Fill takes the strip at the data count, only one strip per cycle
	always_ff @(posedge clk) begin
		if (fill_en)
			strips[fill_idx[0]] <= fill_data;
		else if (wr_hit)
			strips[wr_adr[4]][{wr_adr[3:2], 5'h0} +: 32] <= merged_word;
	end

	// The tag follows the line being fetched
	always_ff @(posedge clk) begin
		if (fill_en)
			line_tag <= fill_tag;
	end

	always_ff @(posedge clk) begin
		if (rst)
			line_valid <= 1'b0;
		else if (fill_en)
			line_valid <= 1'b1;
	end

	assign rd_word = strips[rd_adr[4]][{rd_adr[3:2], 5'h0} +: 32];

endmodule

`default_nettype wire

// ==== logic/mpmc_wb_port.sv ====
`default_nettype none

module mpmc_wb_port (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  mpmc_pkg::sel_t        wb_sel,
	input  mpmc_pkg::addr_t       wb_adr,
	input  mpmc_pkg::word_t       wb_dat_w,
	input  mpmc_pkg::line_tag_t   line_tag,
	input  logic                  line_valid,
	input  mpmc_pkg::word_t       rd_word,
	input  logic                  done_pulse,
	input  mpmc_pkg::mpmc_state_t state,
	output logic                  wb_ack,
	output mpmc_pkg::word_t       wb_dat_r,
	output logic                  start_read,
	output logic                  start_write,
	output mpmc_pkg::strip_t      app_wdf_data,
	output mpmc_pkg::mask_t       app_wdf_mask,
	output logic                  buf_wr_en
);

	logic busy;
	logic done_wait;
	logic can_start;
	logic hit;
	logic hit_ack;
	logic finish;

	// ====================
	// Transfer control
	// ====================

	assign hit = line_valid && (line_tag == wb_adr[31:5]);

	// A new transfer needs an idle controller and a fresh strobe
	assign can_start = wb_cyc && wb_stb && !busy && !done_wait && (state == mpmc_pkg::idle);

	// Read hits are answered from the buffer and never reach memory
	assign hit_ack = can_start && !wb_we && hit;
	assign start_read = can_start && !wb_we && !hit;

	// Writes always go through to memory
	assign start_write = can_start && wb_we;

	assign finish = done_pulse && busy;

	// The buffer copy is merged in the ack cycle, before the next hit check
	assign buf_wr_en = finish && wb_we;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done_wait <= 1'b0;
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= hit_ack || finish;
			if (start_read || start_write)
				busy <= 1'b1;
			else if (finish)
				busy <= 1'b0;
			// The master still shows stb in the cycle after the ack edge
			if (hit_ack || finish)
				done_wait <= 1'b1;
			else if (!(wb_cyc && wb_stb))
				done_wait <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (hit_ack || finish)
			wb_dat_r <= rd_word;
	end

	// ====================
	// Write lane and mask
	// ====================

	// All lanes but the addressed one are masked off
	always_comb begin
		app_wdf_data = '0;
		app_wdf_mask = '1;
		for (int i = 0; i < mpmc_pkg::strip_words; i++) begin
			if (wb_adr[3:2] == 2'(i)) begin
				app_wdf_data[i*32 +: 32] = wb_dat_w;
				app_wdf_mask[i*4 +: 4] = ~wb_sel;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/mpmc_top.sv ====
`default_nettype none

module mpmc_top (
	input  logic              clk,
	input  logic              rst,
	// Wishbone classic slave
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  mpmc_pkg::sel_t    wb_sel,
	input  mpmc_pkg::addr_t   wb_adr,
	input  mpmc_pkg::word_t   wb_dat_w,
	output mpmc_pkg::word_t   wb_dat_r,
	output logic              wb_ack,
	// Application interface to the controller core
	output logic              app_en,
	output logic              app_cmd,
	output mpmc_pkg::addr_t   app_addr,
	output mpmc_pkg::strip_t  app_wdf_data,
	output mpmc_pkg::mask_t   app_wdf_mask,
	input  logic              app_rdy,
	input  mpmc_pkg::strip_t  app_rd_data,
	input  logic              app_rd_data_valid
);

	mpmc_pkg::mpmc_state_t state;
	mpmc_pkg::strip_cnt_t data_cnt;
	mpmc_pkg::line_tag_t line_tag;
	mpmc_pkg::word_t rd_word;
	logic start_read;
	logic start_write;
	logic done_pulse;
	logic req_last;
	logic data_last;
	logic line_valid;
	logic buf_wr_en;

	mpmc_wb_port mpmc_wb_port_inst (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_sel(wb_sel),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.line_tag(line_tag), .line_valid(line_valid), .rd_word(rd_word),
		.done_pulse(done_pulse), .state(state),
		.wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
		.start_read(start_read), .start_write(start_write),
		.app_wdf_data(app_wdf_data), .app_wdf_mask(app_wdf_mask), .buf_wr_en(buf_wr_en)
	);

	mpmc_state_machine mpmc_state_machine_inst (
		.clk(clk), .rst(rst),
		.start_read(start_read), .start_write(start_write), .app_rdy(app_rdy),
		.req_last(req_last), .data_last(data_last), .app_rd_data_valid(app_rd_data_valid),
		.state(state), .app_en(app_en), .app_cmd(app_cmd), .done_pulse(done_pulse)
	);

	// The request count only feeds req_last inside the counter
	mpmc_strip_counter mpmc_strip_counter_inst (
		.clk(clk), .rst(rst), .state(state), .app_rdy(app_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.req_cnt(), .data_cnt(data_cnt), .req_last(req_last), .data_last(data_last)
	);

	mpmc_addr_gen mpmc_addr_gen_inst (
		.clk(clk), .rst(rst), .state(state), .app_rdy(app_rdy),
		.req_last(req_last), .wb_adr(wb_adr), .addr(app_addr)
	);

	// The line tag comes from the address of the strips being fetched
	mpmc_line_buffer mpmc_line_buffer_inst (
		.clk(clk), .rst(rst),
		.fill_en(app_rd_data_valid), .fill_idx(data_cnt), .fill_data(app_rd_data),
		.fill_tag(app_addr[31:5]),
		.wr_en(buf_wr_en), .wr_adr(wb_adr), .wr_data(wb_dat_w), .wr_sel(wb_sel),
		.rd_adr(wb_adr), .rd_word(rd_word), .line_tag(line_tag), .line_valid(line_valid)
	);

endmodule

`default_nettype wire

// ==== test/mpmc_clock_gen.sv ====
`default_nettype none

module mpmc_clock_gen (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period, first rising edge at 50 ns
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset is held for ten rising edges and released on the edge itself
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== test/mpmc_mem_model.sv ====
`default_nettype none

module mpmc_mem_model (
	input  logic              clk,
	input  logic              rst,
	input  logic              app_en,
	input  logic              app_cmd,
	input  mpmc_pkg::addr_t   app_addr,
	input  mpmc_pkg::strip_t  app_wdf_data,
	input  mpmc_pkg::mask_t   app_wdf_mask,
	output logic              app_rdy,
	output mpmc_pkg::strip_t  app_rd_data,
	output logic              app_rd_data_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	// Only written words are stored, all others follow the fill pattern
	mpmc_pkg::word_t mem [mpmc_pkg::addr_t];

	// Pending read returns with the cycle in which each one is due
	mpmc_pkg::strip_t ret_data [$];
	int ret_due [$];
	int cycle;
	int due;
	integer seed;
	logic [31:0] rnd;

	function automatic mpmc_pkg::word_t read_word(input mpmc_pkg::addr_t adr);
		if (mem.exists(adr))
			return mem[adr];
		return adr ^ 32'hA5A5_0000;
	endfunction

	function automatic mpmc_pkg::strip_t read_strip(input mpmc_pkg::addr_t base);
		mpmc_pkg::strip_t s;
		for (int i = 0; i < 4; i++)
			s[i*32 +: 32] = read_word(base + mpmc_pkg::addr_t'(i * 4));
		return s;
	endfunction

	// A set mask bit keeps the stored byte
	task automatic write_strip(input mpmc_pkg::addr_t base, input mpmc_pkg::strip_t data,
			input mpmc_pkg::mask_t mask);
		mpmc_pkg::word_t w;
		for (int i = 0; i < 4; i++) begin
			w = read_word(base + mpmc_pkg::addr_t'(i * 4));
			for (int b = 0; b < 4; b++) begin
				if (!mask[i*4 + b])
					w[b*8 +: 8] = data[(i*4 + b)*8 +: 8];
			end
			mem[base + mpmc_pkg::addr_t'(i * 4)] = w;
		end
	endtask

	initial begin
		seed = 32'h4823_f4f1;
		cycle = 0;
		app_rdy = 1'b0;
		app_rd_data = '0;
		app_rd_data_valid = 1'b0;
	end

	always @(posedge clk) begin
		rnd = $random(seed);
		if (rst) begin
			app_rdy <= 1'b0;
			app_rd_data_valid <= 1'b0;
			ret_data.delete();
			ret_due.delete();
		end else begin
			cycle++;
			// Returns leave in request order, at most one per cycle
			if (ret_due.size() > 0 && ret_due[0] <= cycle) begin
				app_rd_data <= ret_data.pop_front();
				void'(ret_due.pop_front());
				app_rd_data_valid <= 1'b1;
			end else begin
				app_rd_data_valid <= 1'b0;
			end
			if (app_en && app_rdy) begin
				if (app_cmd) begin
					// Read latency of one to four cycles
					due = cycle + 1 + int'(rnd[3:2]);
					if (ret_due.size() > 0 && due <= ret_due[$])
						due = ret_due[$] + 1;
					ret_data.push_back(read_strip({app_addr[31:4], 4'h0}));
					ret_due.push_back(due);
				end else begin
					write_strip({app_addr[31:4], 4'h0}, app_wdf_data, app_wdf_mask);
				end
			end
			// Ready about three cycles out of four
			app_rdy <= (rnd[1:0] != 2'b00);
		end
	end

endmodule

`default_nettype wire

// ==== test/mpmc_tb.sv ====
`default_nettype none

module mpmc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ack_timeout = 200;
	localparam int reset_timeout = 40;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	mpmc_pkg::sel_t wb_sel;
	mpmc_pkg::addr_t wb_adr;
	mpmc_pkg::word_t wb_dat_w;
	mpmc_pkg::word_t wb_dat_r;
	logic wb_ack;
	logic app_en;
	logic app_cmd;
	mpmc_pkg::addr_t app_addr;
	mpmc_pkg::strip_t app_wdf_data;
	mpmc_pkg::mask_t app_wdf_mask;
	logic app_rdy;
	mpmc_pkg::strip_t app_rd_data;
	logic app_rd_data_valid;

	// Requests taken by the memory, as the monitor saw them
	logic req_cmd [$];
	mpmc_pkg::addr_t req_addr [$];
	mpmc_pkg::mask_t req_mask [$];
	mpmc_pkg::strip_t req_data [$];

	// Expected memory content, written words only
	mpmc_pkg::word_t shadow [mpmc_pkg::addr_t];

	int errors;
	int checks;
	int tests;
	integer seed;

	mpmc_clock_gen clock_gen_inst (.clk(clk), .rst(rst));

	mpmc_top mpmc_top_inst (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_sel(wb_sel),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
		.app_wdf_data(app_wdf_data), .app_wdf_mask(app_wdf_mask), .app_rdy(app_rdy),
		.app_rd_data(app_rd_data), .app_rd_data_valid(app_rd_data_valid)
	);

	mpmc_mem_model mpmc_mem_model_inst (
		.clk(clk), .rst(rst),
		.app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
		.app_wdf_data(app_wdf_data), .app_wdf_mask(app_wdf_mask), .app_rdy(app_rdy),
		.app_rd_data(app_rd_data), .app_rd_data_valid(app_rd_data_valid)
	);

	// Every accepted request, sampled with the same edge the memory uses
	always @(posedge clk) begin
		if (!rst && app_en === 1'b1 && app_rdy === 1'b1) begin
			req_cmd.push_back(app_cmd);
			req_addr.push_back(app_addr);
			req_mask.push_back(app_wdf_mask);
			req_data.push_back(app_wdf_data);
		end
	end

	// ====================
	// Reference model
	// ====================

	function automatic mpmc_pkg::word_t shadow_read(input mpmc_pkg::addr_t adr);
		mpmc_pkg::addr_t word_adr;
		word_adr = {adr[31:2], 2'b00};
		if (shadow.exists(word_adr))
			return shadow[word_adr];
		return word_adr ^ 32'hA5A5_0000;
	endfunction

	function automatic void shadow_write(input mpmc_pkg::addr_t adr, input mpmc_pkg::word_t dat,
			input mpmc_pkg::sel_t sel);
		mpmc_pkg::word_t w;
		w = shadow_read(adr);
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				w[b*8 +: 8] = dat[b*8 +: 8];
		end
		shadow[{adr[31:2], 2'b00}] = w;
	endfunction

	// Only the selected bytes of the addressed word may be written
	function automatic mpmc_pkg::mask_t expected_mask(input mpmc_pkg::addr_t adr,
			input mpmc_pkg::sel_t sel);
		mpmc_pkg::mask_t m;
		m = '1;
		for (int b = 0; b < 16; b++) begin
			if (b / 4 == int'(adr[3:2]) && sel[b % 4])
				m[b] = 1'b0;
		end
		return m;
	endfunction

	function automatic void clear_requests();
		req_cmd.delete();
		req_addr.delete();
		req_mask.delete();
		req_data.delete();
	endfunction

	// ====================
	// Checks and bus tasks
	// ====================

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] expected);
		checks++;
		assert (got === expected)
		else begin
			$display("mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout at %0d ns: %s", $time, what);
		$display("Result: FAILED");
		$finish;
	endtask

	// Starts right after a rising edge and returns right after one
	task automatic wb_transfer(input logic we, input mpmc_pkg::addr_t adr,
			input mpmc_pkg::word_t dat, input mpmc_pkg::sel_t sel,
			output mpmc_pkg::word_t rdata, output int latency);
		int cycles;
		cycles = 0;
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_sel <= sel;
		wb_adr <= adr;
		wb_dat_w <= dat;
		do begin
			@(posedge clk);
			cycles++;
		end while (wb_ack !== 1'b1 && cycles < ack_timeout);
		if (wb_ack !== 1'b1) begin
			abort_on_timeout("no wb_ack for a Wishbone transfer");
		end else begin
			rdata = wb_dat_r;
			latency = cycles;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
			// The slave needs to see stb low once before the next transfer
			@(posedge clk);
		end
	endtask

	task automatic read_and_check(input mpmc_pkg::addr_t adr, input logic expect_hit);
		mpmc_pkg::word_t rdata;
		int latency;
		clear_requests();
		wb_transfer(1'b0, adr, '0, 4'hf, rdata, latency);
		check_value("wb_dat_r", rdata, shadow_read(adr));
		if (expect_hit) begin
			// A hit is acked on the edge after stb is first seen
			check_value("hit latency", latency, 2);
			check_value("request count on hit", req_addr.size(), 0);
		end
	endtask

	task automatic write_and_check(input mpmc_pkg::addr_t adr, input mpmc_pkg::word_t dat,
			input mpmc_pkg::sel_t sel);
		mpmc_pkg::word_t rdata;
		int latency;
		clear_requests();
		wb_transfer(1'b1, adr, dat, sel, rdata, latency);
		shadow_write(adr, dat, sel);
		check_value("write request count", req_addr.size(), 1);
		if (req_addr.size() == 1) begin
			check_value("app_cmd", req_cmd[0], 1'b0);
			check_value("app_addr", req_addr[0], {adr[31:4], 4'h0});
			check_value("app_wdf_mask", req_mask[0], expected_mask(adr, sel));
			check_value("app_wdf_data lane", req_data[0][{adr[3:2], 5'h0} +: 32], dat);
		end
	endtask

	task automatic report_test(input string name, input int errors_at_start);
		if (errors == errors_at_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errors_at_start);
		tests++;
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		int errors_at_start;
		int cycles;
		logic [31:0] rnd;
		mpmc_pkg::addr_t adr;
		mpmc_pkg::word_t dat;

		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_sel = '0;
		wb_adr = '0;
		wb_dat_w = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		seed = 32'h4823_f4f1;

		// Outputs are checked at falling edges, away from register updates
		errors_at_start = errors;
		cycles = 0;
		while (rst !== 1'b0 && cycles < reset_timeout) begin
			@(negedge clk);
			cycles++;
			check_value("wb_ack", wb_ack, 1'b0);
			check_value("app_en", app_en, 1'b0);
		end
		if (rst !== 1'b0) begin
			abort_on_timeout("reset was never released");
		end else begin
			repeat (3) begin
				@(negedge clk);
				check_value("wb_ack", wb_ack, 1'b0);
				check_value("app_en", app_en, 1'b0);
			end
		end
		report_test("reset", errors_at_start);
		@(posedge clk);

		// The miss fetches the whole line, lower strip first
		errors_at_start = errors;
		read_and_check(32'h0000_1008, 1'b0);
		check_value("read request count", req_addr.size(), 2);
		if (req_addr.size() == 2) begin
			check_value("app_cmd", req_cmd[0], 1'b1);
			check_value("app_addr", req_addr[0], 32'h0000_1000);
			check_value("app_cmd", req_cmd[1], 1'b1);
			check_value("app_addr", req_addr[1], 32'h0000_1010);
		end
		report_test("read miss", errors_at_start);

		errors_at_start = errors;
		for (int w = 0; w < 8; w++) begin
			if (w != 2)
				read_and_check(32'h0000_1000 + mpmc_pkg::addr_t'(w * 4), 1'b1);
		end
		report_test("read hit", errors_at_start);

		// Partial write outside the buffer, then read it back through a fetch
		errors_at_start = errors;
		write_and_check(32'h0000_2004, 32'hDEAD_BEEF, 4'b0101);
		read_and_check(32'h0000_3000, 1'b0);
		read_and_check(32'h0000_2004, 1'b0);
		report_test("partial write", errors_at_start);

		// Line 0x2000 is buffered now, so the write must update the copy
		errors_at_start = errors;
		write_and_check(32'h0000_2008, 32'h1234_5678, 4'b1111);
		read_and_check(32'h0000_2008, 1'b1);
		read_and_check(32'h0000_2004, 1'b1);
		report_test("write to buffered line", errors_at_start);

		// Eight lines from 0x4000, any word, random direction and selects
		errors_at_start = errors;
		for (int i = 0; i < 48; i++) begin
			rnd = $random(seed);
			adr = 32'h0000_4000 | {24'h0, rnd[2:0], rnd[5:3], 2'b00};
			if (rnd[6]) begin
				dat = $random(seed);
				write_and_check(adr, dat, rnd[10:7]);
			end else begin
				read_and_check(adr, 1'b0);
			end
		end
		report_test("random back-pressure", errors_at_start);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/mpmc_pkg.sv
logic/mpmc_addr_gen.sv
logic/mpmc_strip_counter.sv
logic/mpmc_state_machine.sv
logic/mpmc_line_buffer.sv
logic/mpmc_wb_port.sv
logic/mpmc_top.sv
test/mpmc_clock_gen.sv
test/mpmc_mem_model.sv
test/mpmc_tb.sv

// ==== Bender.yml ====
package:
  name: mpmc

sources:
  - logic/mpmc_pkg.sv
  - logic/mpmc_addr_gen.sv
  - logic/mpmc_strip_counter.sv
  - logic/mpmc_state_machine.sv
  - logic/mpmc_line_buffer.sv
  - logic/mpmc_wb_port.sv
  - logic/mpmc_top.sv
  - target: test
    files:
      - test/mpmc_clock_gen.sv
      - test/mpmc_mem_model.sv
      - test/mpmc_tb.sv
